/* src.f */
+incdir+.
lfsr_pkg.sv
lfsr_state.sv
lfsr_sbox_out.sv
lfsr_prng.sv
tb_lfsr_prng.sv

/* tb_lfsr_model.svh */
`ifndef TB_LFSR_MODEL_SVH
`define TB_LFSR_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// reference model of the register update
////////////////////////////////////////////////////////////////////////////

// ones in the low dw bits
function automatic logic [31:0] width_mask(int dw);
  return 32'hFFFF_FFFF >> (32 - dw);
endfunction

// one clock edge of the register with priority seed over reseed over step over hold
function automatic logic [31:0] step_model(lfsr_type_e flavor, int dw, logic [31:0] dflt,
                                           logic [31:0] cur, logic ld, logic [31:0] seed,
                                           logic en, logic [7:0] ent);
  logic [31:0] msk;
  logic [31:0] taps;
  logic [31:0] nxt;
  logic        fb;
  logic        stuck;
  msk = width_mask(dw);
  cur = cur & msk;
  if (flavor == GAL_XOR) begin
    taps = GAL_XOR_COEFFS[dw - MIN_LFSR_DW];
    stuck = (cur == 32'h0);
  end else begin
    taps = FIB_XNOR_COEFFS[dw - MIN_LFSR_DW];
    stuck = (cur == msk);
  end
  if (ld) begin
    nxt = seed & msk;
  end else if (!en) begin
    nxt = cur;
  end else if (stuck) begin
    nxt = dflt & msk;
  end else if (flavor == GAL_XOR) begin
    // bit 0 falls out and folds the mask back in
    nxt = cur >> 1;
    if (cur[0]) begin
      nxt = nxt ^ taps;
    end
    nxt = (nxt ^ {24'h0, ent}) & msk;
  end else begin
    // xnor of the tapped bits, seeded with one to invert the parity
    fb = 1'b1;
    for (int i = 0; i < dw; i++) begin
      if (taps[i]) begin
        fb = fb ^ cur[i];
      end
    end
    nxt = ((cur << 1) | {31'h0, fb}) ^ {24'h0, ent};
    nxt = nxt & msk;
  end
  return nxt;
endfunction

////////////////////////////////////////////////////////////////////////////
// reference model of the output mapping
////////////////////////////////////////////////////////////////////////////

// row of column col that ends up in front of box number box
function automatic int sbox_row(int n, int col, int box);
  int row;
  case (col)
    0: row = box;
    1: row = (box + n - n / 2) % n;
    2: row = n - 1 - box;
    default: row = (2 * n - 2 - box) % n;
  endcase
  return row;
endfunction

// output tap for a given state with optional sbox layer
function automatic logic [15:0] map_output(int dw, bit nonlin, logic [31:0] st);
  logic [31:0] res;
  logic [3:0]  nib;
  int          n;
  res = st;
  if (nonlin) begin
    n = dw / 4;
    res = '0;
    for (int k = 0; k < n; k++) begin
      // input bit c comes from column c which starts at state bit c*n
      for (int c = 0; c < 4; c++) begin
        nib[c] = st[c * n + sbox_row(n, c, k)];
      end
      res[4 * k +: 4] = SBOX4[nib];
    end
  end
  return res[15:0];
endfunction

`endif

/* tb_lfsr_prng.sv */
`timescale 1ns/100ps

module tb_lfsr_prng;

  import lfsr_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int OUT_DW     = 16;
  localparam int ENT_DW     = 8;
  localparam int DW0        = 32;
  localparam int DW1        = 24;
  localparam int NUM_ROWS   = 15;

  localparam logic [DW0-1:0] SEED0 = 32'h0000_0001;
  localparam logic [DW1-1:0] SEED1 = 24'h00_0001;

  // one stimulus row held for reps cycles
  typedef struct packed {
    logic        seed_en;
    logic [31:0] seed;
    logic        lfsr_en;
    logic        rand_ent;
    logic [7:0]  reps;
  } row_t;

  row_t stim [NUM_ROWS];

  logic              clk_i;
  logic              rst_ni;
  logic              seed_en_i;
  logic [DW0-1:0]    seed_i;
  logic              lfsr_en_i;
  logic [ENT_DW-1:0] entropy_i;
  logic [OUT_DW-1:0] state0;
  logic [OUT_DW-1:0] state1;

  // model registers for each DUT
  logic [31:0] model0;
  logic [31:0] model1;
  logic [31:0] rnd;
  integer      seed_var;
  int          total_cycles = 0;

  `include "tb_lfsr_model.svh"

  ////////////////////////////////////////////////////////////////////////////
  // galois DUT with sbox layer and fibonacci DUT with pass-through
  ////////////////////////////////////////////////////////////////////////////

  lfsr_prng #(
    .LfsrType     (GAL_XOR),
    .LfsrDw       (DW0),
    .EntropyDw    (ENT_DW),
    .StateOutDw   (OUT_DW),
    .DefaultSeed  (SEED0),
    .NonLinearOut (1'b1)
  ) dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .seed_en_i    (seed_en_i),
    .seed_i       (seed_i),
    .lfsr_en_i    (lfsr_en_i),
    .entropy_i    (entropy_i),
    .state_o      (state0)
  );

  // narrower register takes the low seed bits
  lfsr_prng #(
    .LfsrType     (FIB_XNOR),
    .LfsrDw       (DW1),
    .EntropyDw    (ENT_DW),
    .StateOutDw   (OUT_DW),
    .DefaultSeed  (SEED1),
    .NonLinearOut (1'b0)
  ) dut1 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .seed_en_i    (seed_en_i),
    .seed_i       (seed_i[DW1-1:0]),
    .lfsr_en_i    (lfsr_en_i),
    .entropy_i    (entropy_i),
    .state_o      (state1)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_state(input string name, input logic [OUT_DW-1:0] exp_val,
                             input logic [OUT_DW-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("CHECK FAILED at %0d ns: %s expected %h actual %h",
               $time, name, exp_val, act_val);
      $display("Simulation FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic compare_outputs();
    check_state("dut0.state_o", map_output(DW0, 1'b1, model0), state0);
    check_state("dut1.state_o", map_output(DW1, 1'b0, model1), state1);
  endtask

  // each row holds seed_en, seed, lfsr_en, random entropy flag and repeat count
  task automatic fill_table();
    stim[0]  = {1'b0, 32'h0000_0000, 1'b0, 1'b0, 8'd3};   // hold after reset
    stim[1]  = {1'b0, 32'h0000_0000, 1'b1, 1'b0, 8'd40};  // plain stepping
    stim[2]  = {1'b0, 32'h0000_0000, 1'b1, 1'b1, 8'd30};  // entropy mixed in
    stim[3]  = {1'b0, 32'h0000_0000, 1'b0, 1'b0, 8'd2};
    stim[4]  = {1'b1, 32'hA5C3_1E77, 1'b1, 1'b0, 8'd1};   // load beats enable
    stim[5]  = {1'b0, 32'h0000_0000, 1'b1, 1'b1, 8'd10};
    stim[6]  = {1'b1, 32'h0000_0000, 1'b0, 1'b0, 8'd1};   // galois lockup value
    stim[7]  = {1'b0, 32'h0000_0000, 1'b0, 1'b0, 8'd2};
    stim[8]  = {1'b0, 32'h0000_0000, 1'b1, 1'b0, 8'd1};   // reseed edge
    stim[9]  = {1'b0, 32'h0000_0000, 1'b1, 1'b0, 8'd5};
    stim[10] = {1'b1, 32'hFFFF_FFFF, 1'b0, 1'b0, 8'd1};   // fibonacci lockup value
    stim[11] = {1'b0, 32'h0000_0000, 1'b0, 1'b0, 8'd1};
    stim[12] = {1'b0, 32'h0000_0000, 1'b1, 1'b1, 8'd6};
    stim[13] = {1'b1, 32'hFFFF_FFFF, 1'b1, 1'b0, 8'd2};   // repeated load while enabled
    stim[14] = {1'b0, 32'h0000_0000, 1'b1, 1'b1, 8'd20};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    seed_en_i = 1'b0;
    seed_i    = '0;
    lfsr_en_i = 1'b0;
    entropy_i = '0;
    seed_var  = 76;
    fill_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      total_cycles = total_cycles + int'(stim[r].reps);
    end
    model0 = 32'(SEED0);
    model1 = 32'(SEED1);

    // two reset cycles and release on a falling edge
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // check what the last edge produced before driving and advancing the model
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int i = 0; i < int'(stim[r].reps); i++) begin
        @(negedge clk_i);
        compare_outputs();
        seed_en_i = stim[r].seed_en;
        seed_i    = stim[r].seed;
        lfsr_en_i = stim[r].lfsr_en;
        if (stim[r].rand_ent) begin
          rnd       = $random(seed_var);
          entropy_i = rnd[ENT_DW-1:0];
        end else begin
          entropy_i = '0;
        end
        model0 = step_model(GAL_XOR, DW0, 32'(SEED0), model0, seed_en_i, seed_i,
                            lfsr_en_i, entropy_i);
        model1 = step_model(FIB_XNOR, DW1, 32'(SEED1), model1, seed_en_i, seed_i,
                            lfsr_en_i, entropy_i);
      end
    end
    @(negedge clk_i);
    compare_outputs();
    $display("Simulation PASSED");
    $finish;
  end

  // watchdog sized from the table length plus margin
  initial begin
    wait (total_cycles > 0);
    #((total_cycles + 20) * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", total_cycles + 20);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* lfsr_prng.sv */
`timescale 1ns/100ps

module lfsr_prng #(
  // feedback flavor
  parameter lfsr_pkg::lfsr_type_e LfsrType     = lfsr_pkg::GAL_XOR,
  // register width
  parameter int unsigned          LfsrDw       = 32,
  // entropy input width
  parameter int unsigned          EntropyDw    = 8,
  // output tap width
  parameter int unsigned          StateOutDw   = 16,
  // reset and reseed value, must not be the lockup value
  parameter logic [LfsrDw-1:0]    DefaultSeed  = LfsrDw'(1),
  // sbox output layer on or off
  parameter bit                   NonLinearOut = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  seed_en_i,
  input  logic [LfsrDw-1:0]     seed_i,
  input  logic                  lfsr_en_i,
  input  logic [EntropyDw-1:0]  entropy_i,
  output logic [StateOutDw-1:0] state_o
);

  import lfsr_pkg::*;

  // register contents into the output layer
  logic [LfsrDw-1:0] state_q;

  // state register with feedback, reseed and seed load
  lfsr_state #(
    .LfsrType    (LfsrType),
    .LfsrDw      (LfsrDw),
    .EntropyDw   (EntropyDw),
    .DefaultSeed (DefaultSeed)
  ) u_state (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .seed_en_i   (seed_en_i),
    .seed_i      (seed_i),
    .lfsr_en_i   (lfsr_en_i),
    .entropy_i   (entropy_i),
    .state_q_o   (state_q)
  );

  // combinational output mapping
  lfsr_sbox_out #(
    .LfsrDw       (LfsrDw),
    .StateOutDw   (StateOutDw),
    .NonLinearOut (NonLinearOut)
  ) u_sbox_out (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .state_q_i    (state_q),
    .state_o      (state_o)
  );

endmodule

/* lfsr_sbox_out.sv */
`timescale 1ns/100ps

module lfsr_sbox_out #(
  // register width
  parameter int unsigned LfsrDw       = 32,
  // output tap width
  parameter int unsigned StateOutDw   = 16,
  // enable the sbox layer
  parameter bit          NonLinearOut = 1'b0
) (
  // clock and reset only feed the assertions
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [LfsrDw-1:0]     state_q_i,
  output logic [StateOutDw-1:0] state_o
);

  import lfsr_pkg::*;

  // full width result before the output tap
  logic [LfsrDw-1:0] mapped;

  if (NonLinearOut) begin : gen_non_linear
    // one sbox per nibble of state
    localparam int NumSbox = LfsrDw / 4;
    localparam int IdxDw   = $clog2(LfsrDw);

    typedef logic [NumSbox-1:0][IdxDw-1:0] col_t;

    // rows feed the sboxes, columns give their input bit position
    logic [3:0][NumSbox-1:0][IdxDw-1:0] matrix_idx;
    logic [3:0][NumSbox-1:0][IdxDw-1:0] matrix_rr;
    logic [LfsrDw-1:0][IdxDw-1:0]       sbox_src;

    // rotate a column down by shift rows
    function automatic col_t rot_col(col_t col, int shift);
      col_t rot;
      for (int r = 0; r < NumSbox; r++) begin
        rot[(r + shift) % NumSbox] = col[r];
      end
      return rot;
    endfunction

    // flip a column upside down
    function automatic col_t rev_col(col_t col);
      col_t rev;
      for (int r = 0; r < NumSbox; r++) begin
        rev[r] = col[NumSbox-1-r];
      end
      return rev;
    endfunction

    // state bit j goes to column j/N, row j mod N
    for (genvar j = 0; j < LfsrDw; j++) begin : gen_fill
      assign matrix_idx[j / NumSbox][j % NumSbox] = IdxDw'(j);
    end

    // plain column-major filling would let sbox k repeat sbox k+1 one step later
    // so three columns get bent out of line
    always_comb begin
      matrix_rr[0] = matrix_idx[0];
      matrix_rr[1] = rot_col(matrix_idx[1], NumSbox / 2);
      matrix_rr[2] = rev_col(matrix_idx[2]);
      matrix_rr[3] = rev_col(rot_col(matrix_idx[3], 1));
    end

    // read rows out as a flat list, four entries per sbox
    for (genvar k = 0; k < LfsrDw; k++) begin : gen_flat
      assign sbox_src[k] = matrix_rr[k % 4][k / 4];
    end

    // substitution layer
    for (genvar b = 0; b < NumSbox; b++) begin : gen_sbox
      logic [3:0] sbox_in;
      assign sbox_in = {state_q_i[sbox_src[4*b+3]],
                        state_q_i[sbox_src[4*b+2]],
                        state_q_i[sbox_src[4*b+1]],
                        state_q_i[sbox_src[4*b]]};
      assign mapped[4*b +: 4] = SBOX4[sbox_in];
    end

    // the row/column scheme only works out for power of two widths from 16 up
    SboxAlign_A: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      ((2 ** $clog2(LfsrDw)) == LfsrDw) && (LfsrDw >= 16)
    ) else $error("sbox layer needs a power of two width of 16 or more");

  end else begin : gen_pass_thru
    // linear output straight from the register
    assign mapped = state_q_i;
  end

  // low bits form the output tap
  assign state_o = mapped[StateOutDw-1:0];

  // any x here means the register or the index matrix went undefined
  OutKnown_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_o)
  ) else $error("output unknown");

endmodule

/* lfsr_state.sv */
`timescale 1ns/100ps

module lfsr_state #(
  // feedback flavor
  parameter lfsr_pkg::lfsr_type_e LfsrType    = lfsr_pkg::GAL_XOR,
  // register width
  parameter int unsigned          LfsrDw      = 32,
  // entropy bits xor'd into the low end of the state
  parameter int unsigned          EntropyDw   = 8,
  // reset value and lockup reseed value
  parameter logic [LfsrDw-1:0]    DefaultSeed = LfsrDw'(1)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // external seed load, wins over everything else
  input  logic                 seed_en_i,
  input  logic [LfsrDw-1:0]    seed_i,
  // step enable
  input  logic                 lfsr_en_i,
  input  logic [EntropyDw-1:0] entropy_i,
  // full register contents
  output logic [LfsrDw-1:0]    state_q_o
);

  import lfsr_pkg::*;

  // tap mask from the table, cut to the register width
  localparam logic [31:0]       CoeffsFull = lfsr_coeffs(LfsrType, LfsrDw);
  localparam logic [LfsrDw-1:0] Coeffs     = CoeffsFull[LfsrDw-1:0];

  logic [LfsrDw-1:0] lfsr_q;
  logic [LfsrDw-1:0] lfsr_d;
  logic [LfsrDw-1:0] next_state;
  logic [LfsrDw-1:0] entropy_ext;
  logic              lockup;

  // entropy lands on the low state bits
  assign entropy_ext = LfsrDw'(entropy_i);

  ////////////////////////////////////////////////////////////////////////////
  // flavor specific feedback
  ////////////////////////////////////////////////////////////////////////////

  if (LfsrType == GAL_XOR) begin : gen_gal_xor
    // internal xor taps
    // shift right and fold the mask in when bit 0 drops out as one
    assign next_state = entropy_ext
                      ^ ({LfsrDw{lfsr_q[0]}} & Coeffs)
                      ^ (lfsr_q >> 1);

    // all zeros never leaves on its own
    assign lockup = ~(|lfsr_q);

  end else begin : gen_fib_xnor
    // external xnor feedback
    // shift left and fill bit 0 with the inverted tap parity
    assign next_state = entropy_ext
                      ^ {lfsr_q[LfsrDw-2:0], ~(^(lfsr_q & Coeffs))};

    // all ones keeps the xnor parity at one forever
    assign lockup = &lfsr_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // update priority and register
  ////////////////////////////////////////////////////////////////////////////

  // seed load first, then reseed on lockup, then normal step
  always_comb begin
    if (seed_en_i) begin
      lfsr_d = seed_i;
    end else if (lfsr_en_i && lockup) begin
      lfsr_d = DefaultSeed;
    end else if (lfsr_en_i) begin
      lfsr_d = next_state;
    end else begin
      lfsr_d = lfsr_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= DefaultSeed;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  assign state_q_o = lfsr_q;

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  // an external seed shows up on the register one edge later
  SeedLoad_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    seed_en_i |=> (lfsr_q == $past(seed_i))
  ) else $error("seed not loaded");

  // a stuck register is reseeded on the next enabled edge
  // this also catches a DefaultSeed that equals the lockup value
  LockupExit_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (lfsr_en_i && lockup && !seed_en_i) |=> !lockup
  ) else $error("lockup not cleared");

  // mask top bit sets the length
  // a missing entry would leave it clear
  CoeffTop_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    Coeffs[LfsrDw-1]
  ) else $error("tap mask top bit clear");

  // table range and entropy fit
  WidthRange_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (LfsrDw >= MIN_LFSR_DW) && (LfsrDw <= MAX_LFSR_DW) && (EntropyDw <= LfsrDw)
  ) else $error("unsupported width setting");

endmodule

/* lfsr_pkg.sv */
package lfsr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // feedback flavors and width range
  ////////////////////////////////////////////////////////////////////////////

  // galois xor register locks up at all zeros
  // fibonacci xnor register locks up at all ones
  typedef enum logic [1:0] {
    GAL_XOR  = 2'd0,
    FIB_XNOR = 2'd1
  } lfsr_type_e;

  // widths covered by the tap tables below
  localparam int MIN_LFSR_DW = 8;
  localparam int MAX_LFSR_DW = 32;
  localparam int NUM_LFSR_DW = MAX_LFSR_DW - MIN_LFSR_DW + 1;

  ////////////////////////////////////////////////////////////////////////////
  // tap masks
  ////////////////////////////////////////////////////////////////////////////

  // galois xor masks indexed by width minus MIN_LFSR_DW
  // the top set bit of each entry marks the register length
  localparam logic [31:0] GAL_XOR_COEFFS [NUM_LFSR_DW] = '{
    // widths 8 to 15
    32'h0000008E,
    32'h00000108,
    32'h00000204,
    32'h00000402,
    32'h00000829,
    32'h0000100D,
    32'h00002015,
    32'h00004001,
    // widths 16 to 23
    32'h00008016,
    32'h00010004,
    32'h00020013,
    32'h00040013,
    32'h00080004,
    32'h00100002,
    32'h00200001,
    32'h00400010,
    // widths 24 to 32
    32'h0080000D,
    32'h01000004,
    32'h02000023,
    32'h04000013,
    32'h08000004,
    32'h10000002,
    32'h20000029,
    32'h40000004,
    32'h80000057
  };

  // fibonacci xnor masks indexed the same way
  // bits set here are the state bits fed into the parity
  localparam logic [31:0] FIB_XNOR_COEFFS [NUM_LFSR_DW] = '{
    // widths 8 to 15
    32'h000000B8,
    32'h00000110,
    32'h00000240,
    32'h00000500,
    32'h00000829,
    32'h0000100D,
    32'h00002015,
    32'h00006000,
    // widths 16 to 23
    32'h0000D008,
    32'h00012000,
    32'h00020400,
    32'h00040023,
    32'h00090000,
    32'h00140000,
    32'h00300000,
    32'h00420000,
    // widths 24 to 32
    32'h00E10000,
    32'h01200000,
    32'h02000023,
    32'h04000013,
    32'h09000000,
    32'h14000000,
    32'h20000029,
    32'h48000000,
    32'h80200003
  };

  ////////////////////////////////////////////////////////////////////////////
  // substitution box
  ////////////////////////////////////////////////////////////////////////////

  // 4-bit prince sbox, entry i is the image of nibble i
  localparam logic [3:0] SBOX4 [16] = '{
    4'hB, 4'hF, 4'h3, 4'h2,
    4'hA, 4'hC, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0,
    4'hE, 4'h5, 4'hD, 4'h4
  };

  // tap mask lookup by flavor and width
  // widths outside the table give an all-zero mask
  function automatic logic [31:0] lfsr_coeffs(lfsr_type_e lfsr_type, int width);
    int          idx;
    logic [31:0] mask;
    idx  = width - MIN_LFSR_DW;
    mask = '0;
    if ((idx >= 0) && (idx < NUM_LFSR_DW)) begin
      case (lfsr_type)
        GAL_XOR:  mask = GAL_XOR_COEFFS[idx];
        FIB_XNOR: mask = FIB_XNOR_COEFFS[idx];
        default:  mask = '0;
      endcase
    end
    return mask;
  endfunction

endpackage
